// ==== design/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int line_words = 4;
  localparam int way_count  = 4;   // fixed by the two-bit random start

  localparam int byte_bits   = $clog2(data_width / 8);
  localparam int word_bits   = $clog2(line_words);
  localparam int offset_bits = byte_bits + word_bits;
  localparam int line_width  = data_width * line_words;
  localparam int lfsr_width  = 11;

  // the stored tag keeps the whole line address, set index bits included,
  // so a writeback base is rebuilt without knowing the set count
  localparam int tag_width = addr_width - offset_bits;

  typedef logic [addr_width-1:0]        addr_t;
  typedef logic [data_width-1:0]        word_t;
  typedef logic [data_width/8-1:0]      be_t;
  typedef logic [line_width-1:0]        line_t;
  typedef logic [word_bits-1:0]         word_idx_t;
  typedef logic [$clog2(way_count)-1:0] way_t;
  typedef logic [tag_width-1:0]         tag_t;
  typedef logic [lfsr_width-1:0]        lfsr_t;

  typedef enum logic [1:0] {
    st_idle,
    st_writeback,
    st_fill,
    st_install
  } ctrl_state_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

// ==== design/cache_bus_pkg.sv ====
package cache_bus_pkg;

  // cpu holds these stable until waitrequest is seen low
  typedef struct packed {
    logic                 rd;
    logic                 wr;
    cache_cfg_pkg::addr_t addr;
    cache_cfg_pkg::be_t   be;
    cache_cfg_pkg::word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                 rd_valid;
    cache_cfg_pkg::word_t rdata;
    logic                 waitrequest;
  } cpu_rsp_t;

  typedef struct packed {
    logic                 rd;      // single request per four-word burst
    logic                 wr;      // one beat per accepted cycle
    cache_cfg_pkg::addr_t addr;
    cache_cfg_pkg::word_t wdata;
  } mem_req_t;

  typedef struct packed {
    cache_cfg_pkg::word_t rdata;
    logic                 rd_valid;
    logic                 waitrequest;
  } mem_rsp_t;

endpackage

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                      clock,
  input  logic                      reset_n,
  input  cache_bus_pkg::cpu_req_t   cpu_req,
  input  logic                      hit,
  input  cache_cfg_pkg::tag_entry_t victim_entry,
  input  logic                      wb_done,
  input  logic                      fill_done,
  output logic                      waitrequest,
  output logic                      store_write_hit,
  output logic                      store_install,
  output logic                      wb_start,
  output logic                      fill_start,
  output logic                      victim_advance
);
  import cache_cfg_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        access;
  logic        victim_dirty;

  assign access       = cpu_req.rd | cpu_req.wr;
  assign victim_dirty = victim_entry.valid & victim_entry.dirty;

  // only an idle hit lets the cpu through
  assign waitrequest = access & ~(hit & (state == st_idle));

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_comb begin
    state_next      = state;
    store_write_hit = 1'b0;
    store_install   = 1'b0;
    wb_start        = 1'b0;
    fill_start      = 1'b0;
    victim_advance  = 1'b0;

    case (state)
      st_idle: begin
        if (access && hit) begin
          store_write_hit = cpu_req.wr;   // reads need nothing stored
        end else if (access) begin
          if (victim_dirty) begin
            wb_start   = 1'b1;
            state_next = st_writeback;
          end else begin
            fill_start = 1'b1;
            state_next = st_fill;
          end
        end
      end

      st_writeback: begin
        if (wb_done) begin
          fill_start = 1'b1;
          state_next = st_fill;
        end
      end

      st_fill: begin
        if (fill_done)
          state_next = st_install;
      end

      st_install: begin
        store_install = 1'b1;
        // step the lfsr only after the victim way has been written,
        // so the choice stays put for the whole miss
        victim_advance = 1'b1;
        state_next     = st_idle;
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // the victim way and its state stay put for the whole writeback
  assert property (@(posedge clock) disable iff (!reset_n)
    (state == st_writeback) |-> victim_dirty)
    else $error("writeback running on a clean or invalid victim");

  // the held access must hit right after the install
  assert property (@(posedge clock) disable iff (!reset_n)
    (state == st_install) |=> hit)
    else $error("retried access missed after install");

endmodule

// ==== design/cache_store.sv ====
`timescale 1ns/1ps

module cache_store #(
  parameter int n_sets = 4
) (
  input  logic                                clock,
  input  logic                                reset_n,
  input  cache_bus_pkg::cpu_req_t             cpu_req,
  input  cache_cfg_pkg::way_t                 victim_way,
  input  logic                                write_hit,
  input  logic                                install,
  input  cache_cfg_pkg::line_t                fill_line,
  output logic                                hit,
  output cache_cfg_pkg::word_t                rdata,
  output cache_cfg_pkg::tag_entry_t           victim_entry,
  output cache_cfg_pkg::line_t                victim_line,
  output logic [cache_cfg_pkg::way_count-1:0] way_valid,
  output logic [cache_cfg_pkg::way_count-1:0] way_dirty
);
  import cache_cfg_pkg::*;

  localparam int set_bits = $clog2(n_sets);

  tag_t  tag_mem  [way_count][n_sets];
  line_t data_mem [way_count][n_sets];
  logic [n_sets-1:0][way_count-1:0] valid_q;
  logic [n_sets-1:0][way_count-1:0] dirty_q;

  logic [set_bits-1:0]  set_idx;
  word_idx_t            word_idx;
  tag_t                 line_tag;
  logic [way_count-1:0] way_hit;
  way_t                 hit_way;
  line_t                hit_line;
  line_t                merged_line;

  assign set_idx   = cpu_req.addr[offset_bits +: set_bits];
  assign word_idx  = cpu_req.addr[byte_bits +: word_bits];
  assign line_tag  = cpu_req.addr[addr_width-1:offset_bits];
  assign way_valid = valid_q[set_idx];
  assign way_dirty = dirty_q[set_idx];

  // index bits of a stored tag always match its set
  always_comb begin
    for (int w = 0; w < way_count; w++)
      way_hit[w] = valid_q[set_idx][w] &&
                   (tag_mem[w][set_idx][tag_width-1:set_bits] ==
                    line_tag[tag_width-1:set_bits]);
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < way_count; w++)
      if (way_hit[w])
        hit_way = way_t'(w);
  end

  assign hit      = |way_hit;
  assign hit_line = data_mem[hit_way][set_idx];
  assign rdata    = hit_line[word_idx*data_width +: data_width];

  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < data_width/8; b++)
      if (cpu_req.be[b])
        merged_line[word_idx*data_width + b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
  end

  assign victim_entry.valid = valid_q[set_idx][victim_way];
  assign victim_entry.dirty = dirty_q[set_idx][victim_way];
  assign victim_entry.tag   = tag_mem[victim_way][set_idx];
  assign victim_line        = data_mem[victim_way][set_idx];

  always_ff @(posedge clock) begin
    if (install) begin
      data_mem[victim_way][set_idx] <= fill_line;
      tag_mem[victim_way][set_idx]  <= line_tag;
    end else if (write_hit) begin
      data_mem[hit_way][set_idx] <= merged_line;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (install) begin
      valid_q[set_idx][victim_way] <= 1'b1;
      dirty_q[set_idx][victim_way] <= 1'b0;   // filled lines start clean
    end else if (write_hit) begin
      dirty_q[set_idx][hit_way] <= 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (!reset_n)
    (cpu_req.rd || cpu_req.wr) |-> $onehot0(way_hit))
    else $error("several ways hit in set %0d", set_idx);

endmodule

// ==== design/victim_select.sv ====
`timescale 1ns/1ps

module victim_select #(
  parameter cache_cfg_pkg::lfsr_t lfsr_seed = 11'd101
) (
  input  logic                                clock,
  input  logic                                reset_n,
  input  logic                                advance,
  input  logic [cache_cfg_pkg::way_count-1:0] way_valid,
  input  logic [cache_cfg_pkg::way_count-1:0] way_dirty,
  output cache_cfg_pkg::way_t                 victim_way
);
  import cache_cfg_pkg::*;

  lfsr_t lfsr_q;
  way_t  rand_way;

  // x^11 + x^9 + 1 leaping two steps per advance
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n)
      lfsr_q <= lfsr_seed;
    else if (advance)
      lfsr_q <= {lfsr_q[1] ^ lfsr_q[3], lfsr_q[0] ^ lfsr_q[2], lfsr_q[10:2]};
  end

  assign rand_way = lfsr_q[1:0];

  // invalid first, then clean from rand+1 with wrap, else rand itself
  always_comb begin : pick
    logic found;
    way_t cand;
    found      = 1'b0;
    victim_way = rand_way;
    for (int w = 0; w < way_count; w++) begin
      if (!found && !way_valid[w]) begin
        victim_way = way_t'(w);
        found      = 1'b1;
      end
    end
    for (int k = 1; k < way_count; k++) begin
      cand = rand_way + way_t'(k);
      if (!found && !way_dirty[cand]) begin
        victim_way = cand;
        found      = 1'b1;
      end
    end
  end

endmodule

// ==== design/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
  input  logic                      clock,
  input  logic                      reset_n,
  input  cache_cfg_pkg::addr_t      cpu_addr,
  input  cache_cfg_pkg::tag_entry_t victim_entry,
  input  cache_cfg_pkg::line_t      victim_line,
  input  logic                      wb_start,
  input  logic                      fill_start,
  input  cache_bus_pkg::mem_rsp_t   mem_rsp,
  output cache_bus_pkg::mem_req_t   mem_req,
  output cache_cfg_pkg::line_t      fill_line,
  output logic                      wb_done,
  output logic                      fill_done
);
  import cache_cfg_pkg::*;

  localparam addr_t     word_bytes = addr_t'(data_width / 8);
  localparam word_idx_t last_word  = word_idx_t'(line_words - 1);

  logic      rd_q;
  logic      wr_q;
  addr_t     addr_q;
  word_t     wdata_q;
  word_idx_t wr_cnt;
  word_idx_t rd_cnt;
  word_idx_t wr_next;
  logic      fill_pending;
  logic      wr_accept;
  logic      rd_accept;
  logic      last_wr;
  logic      last_rd;
  line_t     fill_buf;

  assign wr_accept = wr_q & ~mem_rsp.waitrequest;
  assign rd_accept = rd_q & ~mem_rsp.waitrequest;
  assign last_wr   = wr_accept && (wr_cnt == last_word);
  assign last_rd   = mem_rsp.rd_valid && (rd_cnt == last_word);
  assign wr_next   = wr_cnt + 1'b1;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      rd_q         <= 1'b0;
      wr_q         <= 1'b0;
      wr_cnt       <= '0;
      rd_cnt       <= '0;
      fill_pending <= 1'b0;
      wb_done      <= 1'b0;
      fill_done    <= 1'b0;
    end else begin
      wb_done   <= last_wr;   // one-cycle pulses
      fill_done <= last_rd;
      if (wb_start) begin
        wr_q   <= 1'b1;
        wr_cnt <= '0;
      end else if (wr_accept) begin
        wr_cnt <= wr_next;
        if (last_wr)
          wr_q <= 1'b0;
      end
      if (fill_start) begin
        rd_q         <= 1'b1;
        rd_cnt       <= '0;
        fill_pending <= 1'b1;
      end else begin
        if (rd_accept)
          rd_q <= 1'b0;
        if (mem_rsp.rd_valid) begin
          rd_cnt <= rd_cnt + 1'b1;
          if (last_rd)
            fill_pending <= 1'b0;
        end
      end
    end
  end

  // victim line stays put in the store for the whole writeback
  always_ff @(posedge clock) begin
    if (wb_start) begin
      addr_q  <= {victim_entry.tag, {offset_bits{1'b0}}};
      wdata_q <= victim_line[0 +: data_width];
    end else if (fill_start) begin
      addr_q <= {cpu_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
    end else if (wr_accept && !last_wr) begin
      addr_q  <= addr_q + word_bytes;
      wdata_q <= victim_line[wr_next*data_width +: data_width];
    end
    if (mem_rsp.rd_valid)
      fill_buf[rd_cnt*data_width +: data_width] <= mem_rsp.rdata;
  end

  assign mem_req.rd    = rd_q;
  assign mem_req.wr    = wr_q;
  assign mem_req.addr  = addr_q;
  assign mem_req.wdata = wdata_q;
  assign fill_line     = fill_buf;

  assert property (@(posedge clock) disable iff (!reset_n)
    mem_rsp.rd_valid |-> fill_pending)
    else $error("read data returned with no fill outstanding");

  // one miss at a time
  assert property (@(posedge clock) disable iff (!reset_n)
    (wb_start || fill_start) |-> !(wr_q || fill_pending))
    else $error("new burst started while another is busy");

endmodule

// ==== design/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
  parameter int                   n_sets    = 4,
  parameter cache_cfg_pkg::lfsr_t lfsr_seed = 11'd101
) (
  input  logic                    clock,
  input  logic                    reset_n,
  input  cache_bus_pkg::cpu_req_t cpu_req,
  output cache_bus_pkg::cpu_rsp_t cpu_rsp,
  output cache_bus_pkg::mem_req_t mem_req,
  input  cache_bus_pkg::mem_rsp_t mem_rsp
);
  import cache_cfg_pkg::*;

  logic                 hit;
  logic                 waitrequest;
  logic                 store_write_hit;
  logic                 store_install;
  logic                 wb_start;
  logic                 fill_start;
  logic                 victim_advance;
  logic                 wb_done;
  logic                 fill_done;
  word_t                rdata;
  tag_entry_t           victim_entry;
  line_t                victim_line;
  line_t                fill_line;
  way_t                 victim_way;
  logic [way_count-1:0] way_valid;
  logic [way_count-1:0] way_dirty;

  assign cpu_rsp.waitrequest = waitrequest;
  assign cpu_rsp.rdata       = rdata;
  assign cpu_rsp.rd_valid    = cpu_req.rd & ~waitrequest;

  cache_ctrl cache_ctrl_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .cpu_req         (cpu_req),
    .hit             (hit),
    .victim_entry    (victim_entry),
    .wb_done         (wb_done),
    .fill_done       (fill_done),
    .waitrequest     (waitrequest),
    .store_write_hit (store_write_hit),
    .store_install   (store_install),
    .wb_start        (wb_start),
    .fill_start      (fill_start),
    .victim_advance  (victim_advance)
  );

  cache_store #(
    .n_sets (n_sets)
  ) cache_store_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .cpu_req      (cpu_req),
    .victim_way   (victim_way),
    .write_hit    (store_write_hit),
    .install      (store_install),
    .fill_line    (fill_line),
    .hit          (hit),
    .rdata        (rdata),
    .victim_entry (victim_entry),
    .victim_line  (victim_line),
    .way_valid    (way_valid),
    .way_dirty    (way_dirty)
  );

  victim_select #(
    .lfsr_seed (lfsr_seed)
  ) victim_select_i (
    .clock      (clock),
    .reset_n    (reset_n),
    .advance    (victim_advance),
    .way_valid  (way_valid),
    .way_dirty  (way_dirty),
    .victim_way (victim_way)
  );

  mem_port mem_port_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .cpu_addr     (cpu_req.addr),
    .victim_entry (victim_entry),
    .victim_line  (victim_line),
    .wb_start     (wb_start),
    .fill_start   (fill_start),
    .mem_rsp      (mem_rsp),
    .mem_req      (mem_req),
    .fill_line    (fill_line),
    .wb_done      (wb_done),
    .fill_done    (fill_done)
  );

endmodule

// ==== sim/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
  parameter cache_cfg_pkg::word_t pattern = 32'h3c96_a55a
) (
  input  logic                    clock,
  input  logic                    reset_n,
  input  cache_bus_pkg::mem_req_t mem_req,
  output cache_bus_pkg::mem_rsp_t mem_rsp
);
  import cache_cfg_pkg::*;

  word_t      mem      [1024];   // 4 KiB window indexed by addr[11:2]
  addr_t      log_addr [1024];
  word_t      log_data [1024];
  int         log_count;
  int         beats_left;
  logic [9:0] rd_idx;

  initial begin
    for (int i = 0; i < 1024; i++)
      mem[i] = word_t'(i * 4) ^ pattern;
    log_count  = 0;
    beats_left = 0;
    rd_idx     = '0;
    mem_rsp    = '0;
  end

  // requests are taken at the rising edge
  always @(posedge clock) begin
    if (reset_n) begin
      if (mem_req.wr && !mem_rsp.waitrequest) begin
        mem[mem_req.addr[11:2]] = mem_req.wdata;
        if (log_count < 1024) begin
          log_addr[log_count] = mem_req.addr;
          log_data[log_count] = mem_req.wdata;
        end
        log_count++;
      end
      if (mem_req.rd && !mem_rsp.waitrequest) begin
        rd_idx     = mem_req.addr[11:2];
        beats_left = line_words;
      end else if (mem_rsp.rd_valid) begin
        rd_idx     = rd_idx + 1'b1;
        beats_left = beats_left - 1;
      end
    end
  end

  // responses change on the falling edge with random stalls and gaps
  always @(negedge clock) begin
    if (!reset_n) begin
      mem_rsp = '0;
    end else begin
      mem_rsp.waitrequest = ($urandom % 4) == 0;
      mem_rsp.rd_valid    = (beats_left > 0) && (($urandom % 3) != 0);
      mem_rsp.rdata       = mem_rsp.rd_valid ? mem[rd_idx] : '0;
    end
  end

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;
  import cache_cfg_pkg::*;
  import cache_bus_pkg::*;

  localparam word_t pattern = 32'h3c96_a55a;

  typedef enum logic [1:0] {op_read, op_write, op_wb_check, op_read_evicted} op_t;

  typedef struct packed {
    op_t        op;
    logic [2:0] grp;
    logic       exp_hit;   // access must finish with no wait
    logic       has_exp;
    addr_t      addr;      // offset only for op_read_evicted
    be_t        be;
    word_t      data;
    word_t      exp_word;
  } entry_t;

  logic     clock;
  logic     reset_n;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  entry_t tests[$];
  word_t  ref_mem [1024];
  int     errors;
  int     errors_mark;
  int     checks;
  int     tests_run;
  int     cycles;
  int     limit;
  int     wb_base;
  addr_t  evicted_base;

  cache_top #(
    .n_sets    (4),
    .lfsr_seed (11'd101)
  ) cache_top_i (
    .clock   (clock),
    .reset_n (reset_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  mem_model #(
    .pattern (pattern)
  ) mem_i (
    .clock   (clock),
    .reset_n (reset_n),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the cache stopped answering after %0d cycles", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input op_t op, input int grp, input logic exp_hit,
                           input logic has_exp, input addr_t addr, input be_t be,
                           input word_t data, input word_t exp_word);
    entry_t e;
    e.op       = op;
    e.grp      = 3'(grp);
    e.exp_hit  = exp_hit;
    e.has_exp  = has_exp;
    e.addr     = addr;
    e.be       = be;
    e.data     = data;
    e.exp_word = exp_word;
    tests.push_back(e);
  endtask

  task automatic build_table();
    int    l;
    addr_t a;
    add_entry(op_read, 1, 0, 1, 32'h010, 4'hf, 0, 32'h010 ^ pattern);   // cold miss
    add_entry(op_read, 1, 1, 1, 32'h01c, 4'hf, 0, 32'h01c ^ pattern);
    add_entry(op_write, 2, 1, 0, 32'h014, 4'b0101, 32'hdead_beef, 0);
    add_entry(op_read, 2, 1, 1, 32'h014, 4'hf, 0,
              ((32'h014 ^ pattern) & 32'hff00_ff00) | (32'hdead_beef & 32'h00ff_00ff));
    // five dirty lines in set 0 and the last one evicts
    for (int i = 0; i < 5; i++)
      add_entry(op_write, 3, 0, 0, 32'h408 + i * 32'h40, 4'hf, 32'ha000_0000 | i, 0);
    add_entry(op_wb_check, 3, 0, 0, 0, 0, 0, 0);
    add_entry(op_read_evicted, 4, 0, 0, 32'h8, 4'hf, 0, 0);
    add_entry(op_read_evicted, 4, 1, 0, 32'h0, 4'hf, 0, 0);
    for (int n = 0; n < 40; n++) begin
      l = $urandom % 12;   // twelve lines over sets 0 and 1
      a = 32'h800 | ((l / 2) << 6) | ((l % 2) << 4) | (($urandom % 4) << 2);
      if ($urandom % 2)
        add_entry(op_write, 5, 0, 0, a, be_t'($urandom % 15 + 1), $urandom, 0);
      else
        add_entry(op_read, 5, 0, 0, a, 4'hf, 0, 0);
    end
  endtask

  task automatic check_idle(input string when);
    checks++;
    if (mem_req.rd !== 1'b0 || mem_req.wr !== 1'b0 || cpu_rsp.waitrequest !== 1'b0) begin
      errors++;
      $display("** Error at %0t: bus not quiet %s (rd %b wr %b waitrequest %b)", $time, when,
               mem_req.rd, mem_req.wr, cpu_rsp.waitrequest);
    end
  endtask

  task automatic check_burst();
    int    beats;
    addr_t base;
    beats = mem_i.log_count - wb_base;
    if (beats != line_words) begin
      errors++;
      $display("%0t: expected one four-beat writeback, memory saw %0d beats", $time, beats);
    end else begin
      base = mem_i.log_addr[wb_base];
      // victim is one of the four lines written first, 0x400 up to 0x4c0
      check_addr(base & ~addr_t'(32'hc0), addr_t'(32'h400),
                 "writeback base is one of the older set 0 lines");
      for (int i = 0; i < line_words; i++) begin
        check_addr(mem_i.log_addr[wb_base + i], base + addr_t'(4 * i), "writeback beat address");
        check_word(mem_i.log_data[wb_base + i], ref_mem[base[11:2] + i], "writeback beat data");
      end
      evicted_base = base;
    end
    wb_base = mem_i.log_count;
  endtask

  task automatic apply_entry(input entry_t e);
    addr_t      a;
    logic [9:0] idx;
    int         waited;
    a   = (e.op == op_read_evicted) ? evicted_base + e.addr : e.addr;
    idx = a[11:2];
    @(negedge clock);
    cpu_req.rd    = (e.op != op_write);
    cpu_req.wr    = (e.op == op_write);
    cpu_req.addr  = a;
    cpu_req.be    = e.be;
    cpu_req.wdata = e.data;
    waited = 0;
    @(posedge clock);
    while (cpu_rsp.waitrequest) begin
      waited++;
      @(posedge clock);
    end
    if (e.op == op_write) begin
      for (int b = 0; b < 4; b++)
        if (e.be[b])
          ref_mem[idx][b*8 +: 8] = e.data[b*8 +: 8];
    end else begin
      if (cpu_rsp.rd_valid !== 1'b1) begin
        errors++;
        $display("** Error at %0t: read of %08h ended without rd_valid", $time, a);
      end
      check_word(cpu_rsp.rdata, ref_mem[idx], $sformatf("read %08h vs reference", a));
      if (e.has_exp)
        check_word(cpu_rsp.rdata, e.exp_word, $sformatf("read %08h vs table", a));
    end
    if (e.exp_hit && waited != 0) begin
      errors++;
      $display("%0t: access to %08h waited %0d cycles, a hit was expected", $time, a, waited);
    end
    @(negedge clock);
    cpu_req.rd = 1'b0;
    cpu_req.wr = 1'b0;
  endtask

  function automatic string test_name(input int grp);
    case (grp)
      0:       return "reset state";
      1:       return "cold reads";
      2:       return "byte-enable write";
      3:       return "writeback burst";
      4:       return "refill after eviction";
      default: return "random mix";
    endcase
  endfunction

  task automatic report_test(input int grp);
    int errs;
    errs = errors - errors_mark;
    $display("test %0d %-22s %s (%0d errors)", grp, test_name(grp), errs == 0 ? "ok" : "bad", errs);
    errors_mark = errors;
    tests_run++;
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clock        = 1'b0;
    reset_n      = 1'b0;
    cpu_req      = '0;
    errors       = 0;
    errors_mark  = 0;
    checks       = 0;
    tests_run    = 0;
    cycles       = 0;
    limit        = 0;
    wb_base      = 0;
    evicted_base = '0;
    void'($urandom(56));
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = word_t'(i * 4) ^ pattern;
    build_table();
    limit = (tests.size() + 1) * 200;   // one slot covers reset
    repeat (8) begin
      @(negedge clock);
      check_idle("during reset");
    end
    reset_n = 1'b1;
    @(negedge clock);
    check_idle("after reset");
    report_test(0);
    for (int i = 0; i < tests.size(); i++) begin
      if (tests[i].op == op_wb_check)
        check_burst();
      else
        apply_entry(tests[i]);
      if (i == tests.size() - 1 || tests[i+1].grp != tests[i].grp)
        report_test(tests[i].grp);
    end
    $display("%0d tests, %0d checks, %0d errors in %0d cycles", tests_run, checks, errors, cycles);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== project.f ====
design/cache_cfg_pkg.sv
design/cache_bus_pkg.sv
design/cache_ctrl.sv
design/cache_store.sv
design/victim_select.sv
design/mem_port.sv
design/cache_top.sv
sim/mem_model.sv
sim/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  - design/cache_cfg_pkg.sv
  - design/cache_bus_pkg.sv
  - design/cache_ctrl.sv
  - design/cache_store.sv
  - design/victim_select.sv
  - design/mem_port.sv
  - design/cache_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/cache_tb.sv
